//--- include/vsub_config.svh
// vector subtract unit configuration
// lane geometry and default prefix network speed
`ifndef VSUB_CONFIG_SVH
`define VSUB_CONFIG_SVH

// number of independent lanes per request
`define VSUB_LANES 4

// width of one lane in bits
`define VSUB_LANE_W 16

// default prefix tree, FAST (sklansky) or SLOW (ripple)
// resolves against speed_e of the package
`define VSUB_SPEED FAST

`endif

//--- design/vsub_pkg.sv
// vector subtract unit package
// enums for prefix speed, opcodes and handshake phase, plus the request,
// lane and result structs
`default_nettype none

`include "vsub_config.svh"

package vsub_pkg;

	// prefix network structure
	typedef enum logic {
		SLOW = 1'b0,
		FAST = 1'b1
	} speed_e;

	// per-request opcode, applied to all lanes alike
	typedef enum logic [1:0] {
		OP_SUB    = 2'd0,
		OP_SUBB   = 2'd1,
		OP_SUBSAT = 2'd2
	} vsub_op_e;

	// four-phase handshake phase
	typedef enum logic {
		HS_IDLE      = 1'b0,
		HS_WAIT_DROP = 1'b1
	} hs_state_e;

	// incoming request, lane 0 in the low bits of a and b
	typedef struct packed {
		vsub_op_e                                 op;
		logic [`VSUB_LANES*`VSUB_LANE_W-1:0] a;
		logic [`VSUB_LANES*`VSUB_LANE_W-1:0] b;
		logic [`VSUB_LANES-1:0]              borrow;
	} vsub_req_t;

	// work for a single lane
	typedef struct packed {
		vsub_op_e                 op;
		logic [`VSUB_LANE_W-1:0] a;
		logic [`VSUB_LANE_W-1:0] b;
		logic                     borrow;
	} lane_op_t;

	// registered output of a single lane
	typedef struct packed {
		logic                     valid;
		logic [`VSUB_LANE_W-1:0] diff;
		logic                     ovf;
	} lane_res_t;

	// packed result returned to the outside
	typedef struct packed {
		logic [`VSUB_LANES*`VSUB_LANE_W-1:0] diff;
		logic [`VSUB_LANES-1:0]              ovf;
	} vsub_res_t;

endpackage

`default_nettype wire

//--- design/prefix_and_or.sv
// parallel-prefix and-or network
// prefix generate/propagate over all lower bit positions, sklansky or ripple
`default_nettype none

module prefix_and_or
	import vsub_pkg::*;
#(
	parameter int     width = 8,
	parameter speed_e speed = FAST
) (
	input  logic [width-1:0] gi,
	input  logic [width-1:0] pi,
	output logic [width-1:0] go,
	output logic [width-1:0] po
);

	generate
		if (speed == FAST) begin : g_fast
			// log-depth sklansky tree
			localparam int levels = $clog2(width);

			// row l holds the partial prefixes after l combine stages
			logic [levels:0][width-1:0] g_lvl;
			logic [levels:0][width-1:0] p_lvl;

			assign g_lvl[0] = gi;
			assign p_lvl[0] = pi;

			for (genvar l = 0; l < levels; l++) begin : g_level
				for (genvar i = 0; i < width; i++) begin : g_bit
					if (((i >> l) & 1) == 1) begin : g_comb
						// top bit of the lower half of this 2^(l+1) group
						localparam int j = ((i >> l) << l) - 1;
						assign g_lvl[l+1][i] = g_lvl[l][i] | (p_lvl[l][i] & g_lvl[l][j]);
						assign p_lvl[l+1][i] = p_lvl[l][i] & p_lvl[l][j];
					end else begin : g_pass
						// lower half of a group passes through unchanged
						assign g_lvl[l+1][i] = g_lvl[l][i];
						assign p_lvl[l+1][i] = p_lvl[l][i];
					end
				end
			end

			assign go = g_lvl[levels];
			assign po = p_lvl[levels];
		end else begin : g_slow
			// serial chain, one combine per bit
			assign go[0] = gi[0];
			assign po[0] = pi[0];

			for (genvar i = 1; i < width; i++) begin : g_chain
				assign go[i] = gi[i] | (pi[i] & go[i-1]);
				assign po[i] = pi[i] & po[i-1];
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- design/sub_v.sv
// parallel-prefix subtractor
// s = a - b - ci with two's-complement overflow flag v
`default_nettype none

`include "vsub_config.svh"

module sub_v
	import vsub_pkg::*;
#(
	parameter int     width = `VSUB_LANE_W,
	parameter speed_e speed = FAST
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             ci,
	output logic [width-1:0] s,
	output logic             v
);

	// subtraction as a + ~b + ~ci
	logic [width-1:0] bi;
	logic             cii;
	logic [width-1:0] gi;
	logic [width-1:0] pi;
	logic [width-1:0] go;
	// half-sum per bit
	logic [width-1:0] pt;

	assign bi  = ~b;
	assign cii = ~ci;

	// bit 0 folds the inverted carry in as a full-adder majority
	assign gi[0] = (a[0] & bi[0]) | (a[0] & cii) | (bi[0] & cii);
	assign pi[0] = 1'b0;
	assign pt[0] = a[0] ^ bi[0];

	generate
		for (genvar i = 1; i < width; i++) begin : g_pre
			assign gi[i] = a[i] & bi[i];
			assign pi[i] = a[i] | bi[i];
			assign pt[i] = ~gi[i] & pi[i];
		end
	endgenerate

	// group propagate unused, carries come from go alone
	prefix_and_or #(
		.width (width),
		.speed (speed)
	) u_prefix (
		.gi (gi),
		.pi (pi),
		.go (go),
		.po ()
	);

	// carry into bit i is go[i-1], carry into bit 0 is cii
	assign s = pt ^ {go[width-2:0], cii};
	// overflow when carry into and out of the sign bit differ
	assign v = go[width-1] ^ go[width-2];

endmodule

`default_nettype wire

//--- design/vsub_lane.sv
// vector subtract lane
// applies the opcode to one prefix subtractor and holds the result until taken
`default_nettype none

`include "vsub_config.svh"

module vsub_lane
	import vsub_pkg::*;
#(
	parameter speed_e speed = FAST
) (
	input  logic      clk,
	input  logic      reset,
	input  lane_op_t  op,
	input  logic      load,
	input  logic      take,
	output logic      ready,
	output lane_res_t res
);

	localparam int W = `VSUB_LANE_W;
	// signed clamp values
	localparam logic [W-1:0] SAT_MAX = {1'b0, {(W-1){1'b1}}};
	localparam logic [W-1:0] SAT_MIN = {1'b1, {(W-1){1'b0}}};

	logic         ci;
	logic [W-1:0] diff_raw;
	logic         ovf_raw;
	logic [W-1:0] diff_d;
	logic         valid_q;
	logic [W-1:0] diff_q;
	logic         ovf_q;

	// borrow only counts for the subtract-with-borrow opcode
	assign ci = (op.op == OP_SUBB) ? op.borrow : 1'b0;

	sub_v #(
		.width (W),
		.speed (speed)
	) u_sub (
		.a  (op.a),
		.b  (op.b),
		.ci (ci),
		.s  (diff_raw),
		.v  (ovf_raw)
	);

	// saturate by sign of a, since overflow means the sign flipped
	always_comb begin
		diff_d = diff_raw;
		if ((op.op == OP_SUBSAT) && ovf_raw) begin
			diff_d = op.a[W-1] ? SAT_MIN : SAT_MAX;
		end
	end

	// slot frees up in the same cycle it is taken
	assign ready = ~valid_q | take;

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
		end else if (take) begin
			valid_q <= 1'b0;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (load) begin
			diff_q <= diff_d;
			ovf_q  <= ovf_raw;
		end
	end

	assign res = '{valid: valid_q, diff: diff_q, ovf: ovf_q};

	// unpacker must respect the lane ready
	a_load_ready: assert property (@(posedge clk) disable iff (reset) load |-> ready);

endmodule

`default_nettype wire

//--- design/vsub_unpack.sv
// request-side four-phase slave
// buffers one request and slices it into per-lane operations
`default_nettype none

`include "vsub_config.svh"

module vsub_unpack
	import vsub_pkg::*;
(
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             req,
	input  vsub_req_t                        req_data,
	output logic                             ack,
	input  logic [`VSUB_LANES-1:0]           lane_ready,
	output logic                             load,
	output lane_op_t [`VSUB_LANES-1:0]       lane_op
);

	localparam int W = `VSUB_LANE_W;

	hs_state_e state_q;
	logic      buf_full_q;
	vsub_req_t buf_q;
	logic      capture;

	// accept only with room in the buffer
	assign capture = (state_q == HS_IDLE) && req && !buf_full_q;
	assign ack     = (state_q == HS_WAIT_DROP);
	// all lanes move together
	assign load    = buf_full_q && (&lane_ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q    <= HS_IDLE;
			buf_full_q <= 1'b0;
		end else begin
			case (state_q)
				HS_IDLE: begin
					if (capture) begin
						state_q <= HS_WAIT_DROP;
					end
				end
				HS_WAIT_DROP: begin
					// wait for master to drop req
					if (!req) begin
						state_q <= HS_IDLE;
					end
				end
				default: state_q <= HS_IDLE;
			endcase
			// capture and load never overlap
			if (capture) begin
				buf_full_q <= 1'b1;
			end else if (load) begin
				buf_full_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			buf_q <= req_data;
		end
	end

	generate
		for (genvar i = 0; i < `VSUB_LANES; i++) begin : g_slice
			assign lane_op[i] = '{
				op:     buf_q.op,
				a:      buf_q.a[i*W +: W],
				b:      buf_q.b[i*W +: W],
				borrow: buf_q.borrow[i]
			};
		end
	endgenerate

	// master holds data until it sees ack
	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		(req && !ack) |=> (!req || ack || $stable(req_data)));

endmodule

`default_nettype wire

//--- design/vsub_collect.sv
// result-side collector
// packs lane results into one result and drives the four-phase result master
`default_nettype none

`include "vsub_config.svh"

module vsub_collect
	import vsub_pkg::*;
(
	input  logic                            clk,
	input  logic                            reset,
	input  lane_res_t [`VSUB_LANES-1:0]     lane_res,
	output logic                            take,
	output logic                            res_req,
	input  logic                            res_ack,
	output vsub_res_t                       res_data
);

	localparam int W = `VSUB_LANE_W;

	hs_state_e              state_q;
	logic                   res_req_q;
	vsub_res_t              res_q;
	vsub_res_t              res_d;
	logic [`VSUB_LANES-1:0] lane_valid;
	logic                   out_full;

	// gather valid bits and pack diff/ovf, lane 0 lowest
	always_comb begin
		for (int i = 0; i < `VSUB_LANES; i++) begin
			lane_valid[i]         = lane_res[i].valid;
			res_d.diff[i*W +: W] = lane_res[i].diff;
			res_d.ovf[i]          = lane_res[i].ovf;
		end
	end

	// output buffer busy from take until res_ack drops
	assign out_full = res_req_q || (state_q == HS_WAIT_DROP);
	assign take     = (&lane_valid) && !out_full;
	assign res_req  = res_req_q;
	assign res_data = res_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q   <= HS_IDLE;
			res_req_q <= 1'b0;
		end else begin
			case (state_q)
				HS_IDLE: begin
					if (take) begin
						res_req_q <= 1'b1;
					end else if (res_req_q && res_ack) begin
						res_req_q <= 1'b0;
						state_q   <= HS_WAIT_DROP;
					end
				end
				HS_WAIT_DROP: begin
					// slave drops ack, buffer frees
					if (!res_ack) begin
						state_q <= HS_IDLE;
					end
				end
				default: state_q <= HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			res_q <= res_d;
		end
	end

	// lanes are loaded and taken together
	a_valid_agree: assert property (@(posedge clk) disable iff (reset)
		(lane_valid == '0) || (&lane_valid));
	a_res_stable: assert property (@(posedge clk) disable iff (reset)
		res_req |=> (!res_req || $stable(res_data)));

endmodule

`default_nettype wire

//--- design/vsub_top.sv
// vector subtract unit top level
// request unpacker, independent subtract lanes and result collector
`default_nettype none

`include "vsub_config.svh"

module vsub_top
	import vsub_pkg::*;
#(
	parameter speed_e speed = `VSUB_SPEED
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      req,
	input  vsub_req_t req_data,
	output logic      ack,
	output logic      res_req,
	input  logic      res_ack,
	output vsub_res_t res_data
);

	logic                             load;
	logic                             take;
	logic [`VSUB_LANES-1:0]           lane_ready;
	lane_op_t [`VSUB_LANES-1:0]       lane_op;
	lane_res_t [`VSUB_LANES-1:0]      lane_res;

	vsub_unpack u_unpack (
		.clk        (clk),
		.reset      (reset),
		.req        (req),
		.req_data   (req_data),
		.ack        (ack),
		.lane_ready (lane_ready),
		.load       (load),
		.lane_op    (lane_op)
	);

	// lanes share load and take, no borrow between them
	generate
		for (genvar i = 0; i < `VSUB_LANES; i++) begin : g_lane
			vsub_lane #(
				.speed (speed)
			) u_lane (
				.clk   (clk),
				.reset (reset),
				.op    (lane_op[i]),
				.load  (load),
				.take  (take),
				.ready (lane_ready[i]),
				.res   (lane_res[i])
			);
		end
	endgenerate

	vsub_collect u_collect (
		.clk      (clk),
		.reset    (reset),
		.lane_res (lane_res),
		.take     (take),
		.res_req  (res_req),
		.res_ack  (res_ack),
		.res_data (res_data)
	);

endmodule

`default_nettype wire

//--- tb/vsub_tb.sv
// vector subtract unit testbench
// directed corner requests and random requests checked against a reference model
`default_nettype none

`include "vsub_config.svh"

module vsub_tb
	import vsub_pkg::*;
();

	localparam int LANES      = `VSUB_LANES;
	localparam int W          = `VSUB_LANE_W;
	localparam int NUM_DIRECT = 6;
	localparam int NUM_RANDOM = 300;
	// 40 cycles per request plus the reset phase
	localparam int TIMEOUT_CYCLES = 40 * (NUM_DIRECT + NUM_RANDOM) + 20;

	logic      clk = 1'b0;
	logic      reset;
	logic      req;
	vsub_req_t req_data;
	logic      ack;
	logic      res_req;
	logic      res_ack;
	vsub_res_t res_data;

	integer    seed = 32'h617c;
	int        cycles = 0;
	int        results = 0;
	int        total = 0;
	logic      start = 1'b0;
	// previous sampled handshake levels
	logic      req_prev = 1'b0;
	logic      ack_prev = 1'b0;
	logic      res_req_prev = 1'b0;
	logic      res_ack_prev = 1'b0;

	vsub_req_t req_q[$];
	vsub_res_t exp_q[$];
	string     name_q[$];

	always #5 clk = ~clk;

	vsub_top u_dut (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.req_data (req_data),
		.ack      (ack),
		.res_req  (res_req),
		.res_ack  (res_ack),
		.res_data (res_data)
	);

	task automatic stop_run();
		$display("Verification failed");
		$fatal(1, "run stopped at first error");
	endtask

	// expected lanes from signed arithmetic in 32 bits, then a range check
	function automatic vsub_res_t ref_vsub(input vsub_req_t r);
		vsub_res_t res;
		int        sa;
		int        sb;
		int        bw;
		int        d;
		int        smax;
		int        smin;
		smax = (1 << (W - 1)) - 1;
		smin = -(1 << (W - 1));
		for (int i = 0; i < LANES; i++) begin
			sa = int'($signed(r.a[i*W +: W]));
			sb = int'($signed(r.b[i*W +: W]));
			bw = (r.op == OP_SUBB) ? int'(r.borrow[i]) : 0;
			d  = sa - sb - bw;
			res.ovf[i] = (d > smax) || (d < smin);
			if ((r.op == OP_SUBSAT) && (d > smax)) begin
				d = smax;
			end else if ((r.op == OP_SUBSAT) && (d < smin)) begin
				d = smin;
			end
			res.diff[i*W +: W] = d[W-1:0];
		end
		return res;
	endfunction

	task automatic check_diff(input string name, input logic [LANES*W-1:0] exp,
			input logic [LANES*W-1:0] act);
		if (act !== exp) begin
			$display("** Error %s: diff expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_ovf(input string name, input logic [LANES-1:0] exp,
			input logic [LANES-1:0] act);
		if (act !== exp) begin
			$display("** Error %s: ovf expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic add_request(input string name, input vsub_op_e op,
			input logic [LANES*W-1:0] a, input logic [LANES*W-1:0] b,
			input logic [LANES-1:0] borrow);
		vsub_req_t r;
		r.op     = op;
		r.a      = a;
		r.b      = b;
		r.borrow = borrow;
		req_q.push_back(r);
		exp_q.push_back(ref_vsub(r));
		name_q.push_back(name);
	endtask

	// one lane operand, a corner value about a quarter of the time
	function automatic logic [W-1:0] rand_lane();
		logic [31:0] pick;
		pick = $random(seed);
		case (pick[3:0])
			4'd0: return '0;
			4'd1: return {1'b0, {(W-1){1'b1}}};
			4'd2: return {1'b1, {(W-1){1'b0}}};
			4'd3: return '1;
			default: return pick[31:32-W];
		endcase
	endfunction

	initial begin : main
		logic [LANES*W-1:0] a;
		logic [LANES*W-1:0] b;
		logic [31:0]        pick;
		vsub_op_e           op;
		reset = 1'b1;
		// lane 3 on the left, lane 0 on the right
		add_request("corner_sub_0", OP_SUB, {16'hffff, 16'h8000, 16'h7fff, 16'h0000},
			{16'hffff, 16'h0001, 16'hffff, 16'h0000}, 4'hf);
		add_request("corner_sub_1", OP_SUB, {16'h0001, 16'h7fff, 16'h0000, 16'h8000},
			{16'h8000, 16'h8000, 16'h7fff, 16'h7fff}, 4'h0);
		// borrow into the signed minimum overflows
		add_request("subb_min", OP_SUBB, {16'h0001, 16'h7fff, 16'h0000, 16'h8000},
			{16'h0001, 16'h7fff, 16'h0000, 16'h0000}, 4'hf);
		add_request("subb_mixed", OP_SUBB, {16'h1234, 16'h8000, 16'hffff, 16'h0000},
			{16'h0034, 16'h0000, 16'hffff, 16'h8000}, 4'b0101);
		add_request("subsat_clamp", OP_SUBSAT, {16'hfff0, 16'h0005, 16'h8000, 16'h7fff},
			{16'h0010, 16'h0003, 16'h0001, 16'hffff}, 4'hf);
		add_request("subsat_edge", OP_SUBSAT, {16'h8000, 16'h7fff, 16'h0000, 16'hffff},
			{16'h7fff, 16'h8000, 16'h8000, 16'h7fff}, 4'h0);
		for (int k = 0; k < NUM_RANDOM; k++) begin
			pick = $random(seed);
			case (pick[1:0])
				2'd0: op = OP_SUB;
				2'd1: op = OP_SUBB;
				default: op = OP_SUBSAT;
			endcase
			for (int i = 0; i < LANES; i++) begin
				a[i*W +: W] = rand_lane();
				b[i*W +: W] = rand_lane();
			end
			pick = $random(seed);
			add_request($sformatf("random_%0d", k), op, a, b, pick[LANES-1:0]);
		end
		total = req_q.size();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		// both handshake outputs idle before the first request
		if ((ack !== 1'b0) || (res_req !== 1'b0)) begin
			$display("ack or res_req is not low after reset");
			stop_run();
		end
		start = 1'b1;
		wait (results == total);
		// give a duplicated result time to show up
		repeat (30) @(posedge clk);
		// both ports back to idle once the last result is acknowledged
		if ((ack === 1'b0) && (res_req === 1'b0)) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("ack or res_req still high after the last result");
			stop_run();
		end
	end

	// four-phase request master
	initial begin : request_master
		vsub_req_t r;
		req      = 1'b0;
		req_data = '0;
		wait (start);
		while (req_q.size() > 0) begin
			r = req_q.pop_front();
			@(posedge clk);
			req      <= 1'b1;
			req_data <= r;
			do @(posedge clk); while (!ack);
			req <= 1'b0;
			do @(posedge clk); while (ack);
		end
	end

	// result slave, random 0..7 cycle delay before ack
	initial begin : result_slave
		int delay;
		res_ack = 1'b0;
		forever begin
			@(posedge clk);
			if (res_req && !res_ack) begin
				delay = $unsigned($random(seed)) % 8;
				repeat (delay) @(posedge clk);
				res_ack <= 1'b1;
				do @(posedge clk); while (res_req);
				res_ack <= 1'b0;
			end
		end
	end

	// one expected entry per rising res_req, in request order
	initial begin : compare
		vsub_res_t exp;
		string     name;
		forever begin
			@(posedge clk);
			if (!reset && res_req && !res_req_prev) begin
				if (exp_q.size() == 0) begin
					$display("result returned with no request outstanding");
					stop_run();
				end
				exp  = exp_q.pop_front();
				name = name_q.pop_front();
				check_diff(name, exp.diff, res_data.diff);
				check_ovf(name, exp.ovf, res_data.ovf);
				results++;
			end
		end
	end

	// four-phase order on both ports
	always @(posedge clk) begin : handshake_monitor
		if (!reset) begin
			if (ack && !ack_prev && !req_prev) begin
				$display("ack rose while req was low");
				stop_run();
			end
			if (!ack && ack_prev && req_prev) begin
				$display("ack dropped while req was still high");
				stop_run();
			end
			if (res_req && !res_req_prev && res_ack_prev) begin
				$display("res_req rose before res_ack dropped");
				stop_run();
			end
			if (!res_req && res_req_prev && !res_ack_prev) begin
				$display("res_req dropped without res_ack");
				stop_run();
			end
		end
		req_prev     <= req;
		ack_prev     <= ack;
		res_req_prev <= res_req;
		res_ack_prev <= res_ack;
	end

	always @(posedge clk) begin : watchdog
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d of %0d results", cycles, results, total);
			stop_run();
		end
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
design/vsub_pkg.sv
design/prefix_and_or.sv
design/sub_v.sv
design/vsub_lane.sv
design/vsub_unpack.sv
design/vsub_collect.sv
design/vsub_top.sv
tb/vsub_tb.sv

//--- Makefile
# Verilator build for the vector subtract unit testbench

TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = vsub_tb
FILELIST   = src.f
BUILD      = obj_dir
LOG        = sim.log
FAIL_MSG   = Verification failed
PASS_MSG   = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
